/* include/imu_defines.svh */
// I2C bus timing in clk_i cycles and the MPU6050 register map, included by RTL and testbench
`ifndef IMU_DEFINES_SVH
`define IMU_DEFINES_SVH

// scl half periods
`define IMU_SCL_LOW_CYC     8'd10
`define IMU_SCL_HIGH_CYC    8'd10

// offsets counted from the last scl edge
`define IMU_START_SETUP_CYC 8'd4   // start setup and sda sample point after rise
`define IMU_DATA_HOLD_CYC   8'd2   // sda change after fall
`define IMU_STOP_SETUP_CYC  8'd3   // sda rise after scl rise for stop
`define IMU_RELEASE_CYC     8'd4   // stop to scl release

// sensor
`define IMU_DEV_ADDR        7'h68
`define IMU_REG_PWR         8'h6B
`define IMU_REG_WHOAMI      8'h75
`define IMU_REG_ACCEL       8'h3B  // ACCEL_XOUT_H, start of the burst
`define IMU_BURST_LEN       4'd14
`define IMU_ERR_ID          8'hE9  // shown on who_am_i after a nack

`endif

/* project.f */
+incdir+include
src/imu_pkg.sv
src/i2c_scl_gen.sv
src/i2c_line_sync.sv
src/i2c_master.sv
src/imu_sequencer.sv
src/imu_sample_assembler.sv
src/imu_reader_top.sv
verif/mpu6050_model.sv
verif/imu_checker.sv
verif/imu_properties.sv
verif/imu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the IMU reader testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f project.f --top-module imu_tb -o imu_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/imu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* src/i2c_line_sync.sv */
// SDA input synchronizer and SCL edge flags that time the I2C bit engine
`timescale 1ns/1ns

module i2c_line_sync (
    input  logic clk_i,
    input  logic rst_i,
    input  logic sda_i,
    input  logic scl_level_i,
    output logic sda_sync_o,
    output logic scl_rise_o,
    output logic scl_fall_o
);

    logic sda_meta;
    logic scl_d;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            sda_meta   <= 1'b1;  // released line reads high
            sda_sync_o <= 1'b1;
            scl_d      <= 1'b1;
        end else begin
            sda_meta   <= sda_i;
            sda_sync_o <= sda_meta;
            scl_d      <= scl_level_i;
        end
    end

    assign scl_rise_o = scl_level_i & ~scl_d;
    assign scl_fall_o = ~scl_level_i & scl_d;

endmodule

/* src/i2c_master.sv */
// I2C master for 8-bit register writes and burst reads, driving open-drain enables
`timescale 1ns/1ns
`include "imu_defines.svh"

module i2c_master import imu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_valid_i,
    input  i2c_req_t    req_i,
    input  logic        sda_i,
    output i2c_status_t status_o,
    output i2c_rdata_t  rdata_o,
    output logic        scl_oe_o,
    output logic        sda_oe_o
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_TX, ST_ACK_RX, ST_RESTART,
        ST_RX, ST_ACK_TX, ST_ACK_END, ST_STOP, ST_RELEASE
    } state_t;

    // byte of the frame now on the wire
    typedef enum logic [1:0] {STEP_ADDR_W, STEP_REG, STEP_WDATA, STEP_ADDR_R} step_t;

    state_t     state;
    step_t      step;
    i2c_req_t   req_q;
    logic       en_scl;
    logic       sda_out;  // 0 pulls the line low
    logic       scl_level;
    logic [7:0] phase_cnt;
    logic       sda_sync;
    logic       scl_rise;
    logic       scl_fall;
    logic       rise_seen;
    logic       fall_seen;
    logic       drive_pt;
    logic       samp_pt;
    logic [3:0] bit_cnt;
    logic [3:0] byte_cnt;
    logic       last_byte;
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;

    i2c_scl_gen scl_gen_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_scl),
        .scl_level_o (scl_level),
        .phase_cnt_o (phase_cnt)
    );

    i2c_line_sync line_sync_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sda_i       (sda_i),
        .scl_level_i (scl_level),
        .sda_sync_o  (sda_sync),
        .scl_rise_o  (scl_rise),
        .scl_fall_o  (scl_fall)
    );

    // one drive point per low phase, one sample point per high phase
    assign drive_pt = fall_seen && (phase_cnt == `IMU_DATA_HOLD_CYC);
    assign samp_pt  = rise_seen && (phase_cnt == `IMU_START_SETUP_CYC);

    assign scl_oe_o = en_scl & ~scl_level;
    assign sda_oe_o = ~sda_out;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rise_seen <= 1'b0;
            fall_seen <= 1'b0;
        end else if (!en_scl) begin
            rise_seen <= 1'b0;
            fall_seen <= 1'b0;
        end else begin
            rise_seen <= scl_rise | (rise_seen & ~samp_pt & ~scl_fall);
            fall_seen <= scl_fall | (fall_seen & ~drive_pt & ~scl_rise);
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state     <= ST_IDLE;
            step      <= STEP_ADDR_W;
            req_q     <= '0;
            en_scl    <= 1'b0;
            sda_out   <= 1'b1;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            last_byte <= 1'b0;
            tx_sr     <= '0;
            rx_sr     <= '0;
            status_o  <= '0;
            rdata_o   <= '0;
        end else begin
            rdata_o.valid <= 1'b0;
            case (state)
                ST_IDLE: if (req_valid_i) begin
                    req_q           <= req_i;
                    status_o.busy   <= 1'b1;
                    status_o.nack   <= 1'b0;
                    en_scl          <= 1'b1;
                    step            <= STEP_ADDR_W;
                    tx_sr           <= {`IMU_DEV_ADDR, 1'b0};
                    bit_cnt         <= '0;
                    byte_cnt        <= '0;
                    state           <= ST_START;
                end
                ST_START: if (scl_level && phase_cnt == `IMU_START_SETUP_CYC) begin
                    sda_out <= 1'b0;  // start
                    state   <= ST_TX;
                end
                ST_TX: if (drive_pt) begin
                    if (bit_cnt == 4'd8) begin
                        sda_out <= 1'b1;  // hand the line to the slave ack
                        bit_cnt <= '0;
                        state   <= ST_ACK_RX;
                    end else begin
                        sda_out <= tx_sr[7];
                        tx_sr   <= {tx_sr[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                ST_ACK_RX: if (samp_pt) begin
                    if (sda_sync) begin
                        // no ack, abort and let scl float high
                        status_o.busy <= 1'b0;
                        status_o.nack <= 1'b1;
                        en_scl        <= 1'b0;
                        state         <= ST_IDLE;
                    end else begin
                        case (step)
                            STEP_ADDR_W: begin
                                tx_sr <= req_q.reg_addr;
                                step  <= STEP_REG;
                                state <= ST_TX;
                            end
                            STEP_REG: begin
                                tx_sr <= req_q.wdata;
                                step  <= STEP_WDATA;
                                state <= req_q.rw ? ST_RESTART : ST_TX;
                            end
                            STEP_WDATA: state <= ST_STOP;  // single byte write
                            default:    state <= ST_RX;
                        endcase
                    end
                end
                ST_RESTART: if (samp_pt) begin
                    sda_out <= 1'b0;  // repeated start
                    tx_sr   <= {`IMU_DEV_ADDR, 1'b1};
                    step    <= STEP_ADDR_R;
                    state   <= ST_TX;
                end
                ST_RX: if (samp_pt) begin
                    rx_sr <= {rx_sr[6:0], sda_sync};  // msb first
                    if (bit_cnt == 4'd7) begin
                        rdata_o.data  <= {rx_sr[6:0], sda_sync};
                        rdata_o.valid <= 1'b1;
                        last_byte     <= (byte_cnt == req_q.byte_len - 4'd1);
                        byte_cnt      <= byte_cnt + 4'd1;
                        bit_cnt       <= '0;
                        state         <= ST_ACK_TX;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                ST_ACK_TX: if (drive_pt) begin
                    sda_out <= last_byte;  // nack after the last byte
                    state   <= ST_ACK_END;
                end
                ST_ACK_END: if (drive_pt) begin
                    sda_out <= ~last_byte;  // held low into the stop
                    state   <= last_byte ? ST_STOP : ST_RX;
                end
                ST_STOP: begin
                    if (drive_pt) begin
                        sda_out <= 1'b0;
                    end else if (rise_seen && phase_cnt == `IMU_STOP_SETUP_CYC) begin
                        sda_out <= 1'b1;  // stop
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: if (phase_cnt == `IMU_STOP_SETUP_CYC + `IMU_RELEASE_CYC) begin
                    en_scl        <= 1'b0;  // before scl can fall again
                    status_o.busy <= 1'b0;
                    state         <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* src/i2c_scl_gen.sv */
// SCL divider for the I2C master, high with a cleared phase count whenever it is disabled
`timescale 1ns/1ns
`include "imu_defines.svh"

module i2c_scl_gen (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       en_i,
    output logic       scl_level_o,
    output logic [7:0] phase_cnt_o
);

    logic phase_end;

    // last cycle of the current half period
    assign phase_end = scl_level_o ? (phase_cnt_o == `IMU_SCL_HIGH_CYC - 8'd1)
                                   : (phase_cnt_o == `IMU_SCL_LOW_CYC - 8'd1);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            scl_level_o <= 1'b1;
            phase_cnt_o <= '0;
        end else if (!en_i) begin
            scl_level_o <= 1'b1;  // idle bus level
            phase_cnt_o <= '0;
        end else if (phase_end) begin
            scl_level_o <= ~scl_level_o;
            phase_cnt_o <= '0;
        end else begin
            phase_cnt_o <= phase_cnt_o + 8'd1;
        end
    end

endmodule

/* src/imu_pkg.sv */
// struct types shared by the I2C master and the IMU reader, imported by the RTL modules
package imu_pkg;

    // one transaction for the i2c master
    typedef struct packed {
        logic       rw;        // 1 = read
        logic [7:0] reg_addr;
        logic [7:0] wdata;     // write only
        logic [3:0] byte_len;  // bytes to read
    } i2c_req_t;

    typedef struct packed {
        logic busy;
        logic nack;  // held until the next request
    } i2c_status_t;

    // one received byte, valid for a single cycle
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } i2c_rdata_t;

    // burst fields in register order, temperature dropped
    typedef struct packed {
        logic signed [15:0] ax;
        logic signed [15:0] ay;
        logic signed [15:0] az;
        logic signed [15:0] gx;
        logic signed [15:0] gy;
        logic signed [15:0] gz;
    } imu_sample_t;

endpackage

/* src/imu_reader_top.sv */
// MPU6050 reader top level, connecting sequencer, I2C master and sample assembler
`timescale 1ns/1ns

module imu_reader_top import imu_pkg::*; #(
    parameter int unsigned WAKE_DELAY_CYC = 100_000_000  // cycles after the wake write
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        sda_i,
    output logic        scl_oe_o,
    output logic        sda_oe_o,
    output logic        sample_valid_o,
    output logic        error_o,
    output logic [7:0]  who_am_i_o,
    output logic [31:0] data1_o,
    output logic [31:0] data2_o,
    output logic [31:0] data3_o
);

    i2c_req_t    req;
    logic        req_valid;
    i2c_status_t status;
    i2c_rdata_t  rdata;
    logic        burst_start;

    imu_sequencer #(
        .WAKE_DELAY_CYC (WAKE_DELAY_CYC)
    ) seq_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .status_i      (status),
        .rdata_i       (rdata),
        .req_o         (req),
        .req_valid_o   (req_valid),
        .burst_start_o (burst_start),
        .error_o       (error_o),
        .who_am_i_o    (who_am_i_o)
    );

    i2c_master master_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .sda_i       (sda_i),
        .status_o    (status),
        .rdata_o     (rdata),
        .scl_oe_o    (scl_oe_o),
        .sda_oe_o    (sda_oe_o)
    );

    imu_sample_assembler asm_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .burst_start_i  (burst_start),
        .rdata_i        (rdata),
        .sample_valid_o (sample_valid_o),
        .data1_o        (data1_o),
        .data2_o        (data2_o),
        .data3_o        (data3_o)
    );

endmodule

/* src/imu_sample_assembler.sv */
// collects burst bytes into the sample fields and publishes the three packed data words
`timescale 1ns/1ns
`include "imu_defines.svh"

module imu_sample_assembler import imu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        burst_start_i,
    input  i2c_rdata_t  rdata_i,
    output logic        sample_valid_o,
    output logic [31:0] data1_o,
    output logic [31:0] data2_o,
    output logic [31:0] data3_o
);

    logic [3:0]  byte_idx;
    imu_sample_t acc_q;
    imu_sample_t acc_d;
    logic        last;

    // high byte first, bytes 6 and 7 are temperature
    always_comb begin
        acc_d = acc_q;
        case (byte_idx)
            4'd0:    acc_d.ax[15:8] = rdata_i.data;
            4'd1:    acc_d.ax[7:0]  = rdata_i.data;
            4'd2:    acc_d.ay[15:8] = rdata_i.data;
            4'd3:    acc_d.ay[7:0]  = rdata_i.data;
            4'd4:    acc_d.az[15:8] = rdata_i.data;
            4'd5:    acc_d.az[7:0]  = rdata_i.data;
            4'd8:    acc_d.gx[15:8] = rdata_i.data;
            4'd9:    acc_d.gx[7:0]  = rdata_i.data;
            4'd10:   acc_d.gy[15:8] = rdata_i.data;
            4'd11:   acc_d.gy[7:0]  = rdata_i.data;
            4'd12:   acc_d.gz[15:8] = rdata_i.data;
            4'd13:   acc_d.gz[7:0]  = rdata_i.data;
            default: ;
        endcase
    end

    assign last = rdata_i.valid && (byte_idx == `IMU_BURST_LEN - 4'd1);

    always_ff @(posedge clk_i) begin
        if (rdata_i.valid)
            acc_q <= acc_d;
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            byte_idx       <= '0;
            sample_valid_o <= 1'b0;
            data1_o        <= '0;
            data2_o        <= '0;
            data3_o        <= '0;
        end else begin
            sample_valid_o <= last;
            if (burst_start_i)
                byte_idx <= '0;
            else if (rdata_i.valid)
                byte_idx <= byte_idx + 4'd1;
            if (last) begin  // words move together with the strobe
                data1_o <= {acc_d.ay, acc_d.ax};
                data2_o <= {acc_d.gx, acc_d.az};
                data3_o <= {acc_d.gz, acc_d.gy};
            end
        end
    end

endmodule

/* src/imu_sequencer.sv */
// command sequencer: wakes the MPU6050, reads WHO_AM_I, then repeats 14-byte bursts
`timescale 1ns/1ns
`include "imu_defines.svh"

module imu_sequencer import imu_pkg::*; #(
    parameter int unsigned WAKE_DELAY_CYC = 100_000_000
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  i2c_status_t status_i,
    input  i2c_rdata_t  rdata_i,
    output i2c_req_t    req_o,
    output logic        req_valid_o,
    output logic        burst_start_o,
    output logic        error_o,
    output logic [7:0]  who_am_i_o
);

    typedef enum logic [2:0] {ST_REQ, ST_GO, ST_RUN, ST_DELAY, ST_ERROR} state_t;
    typedef enum logic [1:0] {OP_WAKE, OP_ID, OP_BURST} op_t;

    state_t      state;
    op_t         op;
    logic [31:0] delay_cnt;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state         <= ST_REQ;
            op            <= OP_WAKE;
            delay_cnt     <= '0;
            req_o         <= '0;
            req_valid_o   <= 1'b0;
            burst_start_o <= 1'b0;
            error_o       <= 1'b0;
            who_am_i_o    <= '0;
        end else begin
            req_valid_o   <= 1'b0;
            burst_start_o <= 1'b0;
            case (state)
                ST_REQ: if (!status_i.busy) begin
                    req_valid_o   <= 1'b1;
                    burst_start_o <= (op == OP_BURST);
                    state         <= ST_GO;
                    case (op)
                        OP_WAKE: req_o <= '{rw: 1'b0, reg_addr: `IMU_REG_PWR,
                                           wdata: 8'h00, byte_len: 4'd1};
                        OP_ID:   req_o <= '{rw: 1'b1, reg_addr: `IMU_REG_WHOAMI,
                                           wdata: 8'h00, byte_len: 4'd1};
                        default: req_o <= '{rw: 1'b1, reg_addr: `IMU_REG_ACCEL,
                                           wdata: 8'h00, byte_len: `IMU_BURST_LEN};
                    endcase
                end
                ST_GO: state <= ST_RUN;  // master busy shows up next cycle
                ST_RUN: begin
                    if (op == OP_ID && rdata_i.valid)
                        who_am_i_o <= rdata_i.data;
                    if (!status_i.busy) begin
                        state <= (op == OP_WAKE) ? ST_DELAY : ST_REQ;
                        if (op == OP_ID)
                            op <= OP_BURST;
                    end
                end
                ST_DELAY: begin
                    if (delay_cnt == WAKE_DELAY_CYC - 1) begin  // sensor out of sleep
                        delay_cnt <= '0;
                        op        <= OP_ID;
                        state     <= ST_REQ;
                    end else begin
                        delay_cnt <= delay_cnt + 32'd1;
                    end
                end
                default: begin
                    error_o    <= 1'b1;
                    who_am_i_o <= `IMU_ERR_ID;
                end
            endcase
            if (status_i.nack)
                state <= ST_ERROR;  // sticky
        end
    end

endmodule

/* verif/imu_checker.sv */
// compares the IMU reader outputs with the expected values from the testbench and counts errors
`timescale 1ns/1ns

module imu_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        done_i,
    input  logic        sample_valid_i,
    input  logic        error_i,
    input  logic        scl_oe_i,
    input  logic        sda_oe_i,
    input  logic [7:0]  who_am_i_i,
    input  logic [31:0] data1_i,
    input  logic [31:0] data2_i,
    input  logic [31:0] data3_i,
    input  logic [31:0] exp1_i,
    input  logic [31:0] exp2_i,
    input  logic [31:0] exp3_i,
    input  logic        exp_nack_i,
    input  logic [7:0]  wr_cnt_i,
    input  logic [7:0]  wr_reg_i,
    input  logic [7:0]  wr_data_i,
    input  logic        rd_before_wr_i,
    output int          err_cnt_o
);

    int   tests;
    int   bursts;
    int   mark;   // error count at the start of a test
    logic rst_q;
    logic done_q;
    logic id_seen;
    logic err_seen;

    initial begin
        err_cnt_o = 0;
        tests = 0;
        bursts = 0;
        mark = 0;
        rst_q = 1'b1;
        done_q = 1'b0;
        id_seen = 1'b0;
        err_seen = 1'b0;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            err_cnt_o++;
        end
    endtask

    task automatic fail(input string what);
        $display("Error at %0t ns: %s", $time, what);
        err_cnt_o++;
    endtask

    task automatic close_test(input string name);
        tests++;
        $display("test %-10s %s", name, (err_cnt_o == mark) ? "passed" : "FAILED");
    endtask

    always @(posedge clk_i) begin
        if (rst_q && !rst_i) begin  // first cycle out of reset
            mark = err_cnt_o;
            check_val("sample_valid_o", 32'(sample_valid_i), 0);
            check_val("error_o", 32'(error_i), 0);
            check_val("scl_oe_o", 32'(scl_oe_i), 0);
            check_val("sda_oe_o", 32'(sda_oe_i), 0);
            check_val("who_am_i_o", 32'(who_am_i_i), 0);
            check_val("data1_o", data1_i, 0);
            check_val("data2_o", data2_i, 0);
            check_val("data3_o", data3_i, 0);
            close_test("reset");
        end
        if (!rst_i && !id_seen && who_am_i_i != 8'h00) begin
            id_seen = 1'b1;
            mark = err_cnt_o;
            check_val("write count", 32'(wr_cnt_i), 1);
            check_val("write register", 32'(wr_reg_i), 32'h6B);
            check_val("write data", 32'(wr_data_i), 0);
            if (rd_before_wr_i)
                fail("a read started before the wake write");
            close_test("wake");
            mark = err_cnt_o;
            check_val("who_am_i_o", 32'(who_am_i_i), 32'h68);
            check_val("error_o", 32'(error_i), 0);
            close_test("who_am_i");
        end
        if (sample_valid_i) begin
            mark = err_cnt_o;
            if (err_seen) begin
                fail("sample strobe after the error");
            end else begin
                check_val("data1_o", data1_i, exp1_i);
                check_val("data2_o", data2_i, exp2_i);
                check_val("data3_o", data3_i, exp3_i);
                bursts++;
            end
            close_test("burst");
        end
        if (error_i && !err_seen) begin
            err_seen = 1'b1;
            mark = err_cnt_o;
            if (!exp_nack_i)
                fail("error_o rose without a NACK from the sensor");
            check_val("who_am_i_o", 32'(who_am_i_i), 32'hE9);
            close_test("nack");
        end
        if (done_i && !done_q) begin
            mark = err_cnt_o;
            check_val("scl_oe_o", 32'(scl_oe_i), 0);
            check_val("sda_oe_o", 32'(sda_oe_i), 0);
            if (!err_seen)
                fail("error_o never rose");
            if (bursts != 3)
                fail("wrong number of good bursts");
            close_test("idle");
            if (tests != 8)
                fail("not all tests ran");
            $display("tests %0d, errors %0d", tests, err_cnt_o);
        end
        rst_q <= rst_i;
        done_q <= done_i;
    end

endmodule

/* verif/imu_properties.sv */
// concurrent assertions on the IMU reader strobes and bus enables, bound to the top level
`timescale 1ns/1ns

module imu_properties (
    input logic clk_i,
    input logic rst_i,
    input logic sample_valid_i,
    input logic error_i,
    input logic scl_oe_i,
    input logic sda_oe_i
);

    a_strobe_single: assert property (@(posedge clk_i) disable iff (rst_i)
        sample_valid_i |=> !sample_valid_i)
        else $error("sample_valid_o high for two cycles");

    // with scl released only start and stop move sda, never at an scl edge
    a_sda_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (sda_oe_i != $past(sda_oe_i)) && !scl_oe_i |-> !$past(scl_oe_i))
        else $error("sda_oe_o changed at an SCL edge");

    a_error_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        error_i |=> error_i)
        else $error("error_o fell after being set");

endmodule

bind imu_reader_top imu_properties props_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .sample_valid_i (sample_valid_o),
    .error_i        (error_o),
    .scl_oe_i       (scl_oe_o),
    .sda_oe_i       (sda_oe_o)
);

/* verif/imu_tb.sv */
// testbench top for the IMU reader with clock, reset, burst table, stimulus loop and watchdog
`timescale 1ns/1ns
`include "imu_defines.svh"

module imu_tb;

    localparam int CLK_NS    = 4;
    localparam int WAKE_CYC  = 200;
    localparam int BIT_CYC   = int'(`IMU_SCL_LOW_CYC) + int'(`IMU_SCL_HIGH_CYC);
    localparam int LIMIT_NS  = 5 * 20 * 9 * BIT_CYC * CLK_NS + WAKE_CYC * CLK_NS + 16 * CLK_NS;
    localparam int N_ENTRIES = 4;

    logic         clk_i;
    logic         rst_i;
    logic         scl_oe;
    logic         sda_oe;
    logic         model_sda_oe;
    logic         scl;
    logic         sda;
    logic         sample_valid;
    logic         error;
    logic [7:0]   who_am_i;
    logic [31:0]  data1;
    logic [31:0]  data2;
    logic [31:0]  data3;
    logic [111:0] burst_q;
    logic         nack_q;
    logic [31:0]  exp1;
    logic [31:0]  exp2;
    logic [31:0]  exp3;
    logic         done;
    logic [7:0]   wr_cnt;
    logic [7:0]   wr_reg;
    logic [7:0]   wr_data;
    logic         rd_before_wr;
    int           err_cnt;
    integer       seed;

    // stimulus table with one burst per entry
    logic [111:0] tbl_burst [N_ENTRIES];
    logic [31:0]  tbl_d1    [N_ENTRIES];
    logic [31:0]  tbl_d2    [N_ENTRIES];
    logic [31:0]  tbl_d3    [N_ENTRIES];
    logic         tbl_nack  [N_ENTRIES];

    assign scl = ~scl_oe;                   // pull-up without stretching
    assign sda = ~(sda_oe | model_sda_oe);  // wired and

    imu_reader_top #(
        .WAKE_DELAY_CYC (WAKE_CYC)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sda_i          (sda),
        .scl_oe_o       (scl_oe),
        .sda_oe_o       (sda_oe),
        .sample_valid_o (sample_valid),
        .error_o        (error),
        .who_am_i_o     (who_am_i),
        .data1_o        (data1),
        .data2_o        (data2),
        .data3_o        (data3)
    );

    mpu6050_model model_i (
        .scl_i          (scl),
        .sda_i          (sda),
        .burst_i        (burst_q),
        .nack_addr_i    (nack_q),
        .sda_oe_o       (model_sda_oe),
        .wr_cnt_o       (wr_cnt),
        .wr_reg_o       (wr_reg),
        .wr_data_o      (wr_data),
        .rd_before_wr_o (rd_before_wr)
    );

    imu_checker chk_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .done_i         (done),
        .sample_valid_i (sample_valid),
        .error_i        (error),
        .scl_oe_i       (scl_oe),
        .sda_oe_i       (sda_oe),
        .who_am_i_i     (who_am_i),
        .data1_i        (data1),
        .data2_i        (data2),
        .data3_i        (data3),
        .exp1_i         (exp1),
        .exp2_i         (exp2),
        .exp3_i         (exp3),
        .exp_nack_i     (nack_q),
        .wr_cnt_i       (wr_cnt),
        .wr_reg_i       (wr_reg),
        .wr_data_i      (wr_data),
        .rd_before_wr_i (rd_before_wr),
        .err_cnt_o      (err_cnt)
    );

    always #(CLK_NS / 2) clk_i = ~clk_i;

    // fields are high byte first with temperature bytes 6 and 7 skipped
    task automatic build_table();
        logic [7:0] b [14];
        for (int e = 0; e < N_ENTRIES; e++) begin
            for (int k = 0; k < 14; k++) begin
                b[k] = 8'($random(seed));
                tbl_burst[e][111 - 8 * k -: 8] = b[k];
            end
            tbl_d1[e]   = {b[2], b[3], b[0], b[1]};     // ay, ax
            tbl_d2[e]   = {b[8], b[9], b[4], b[5]};     // gx, az
            tbl_d3[e]   = {b[12], b[13], b[10], b[11]}; // gz, gy
            tbl_nack[e] = (e == 3);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        burst_q = '0;
        nack_q = 1'b0;
        exp1 = '0;
        exp2 = '0;
        exp3 = '0;
        done = 1'b0;
        seed = 19101;
        build_table();
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            burst_q <= tbl_burst[e];
            nack_q  <= tbl_nack[e];
            exp1    <= tbl_d1[e];
            exp2    <= tbl_d2[e];
            exp3    <= tbl_d3[e];
            do @(negedge clk_i); while (!sample_valid && !error);
            @(posedge clk_i);
        end
        repeat (2 * 9 * BIT_CYC) @(posedge clk_i);  // quiet bus after the error
        done <= 1'b1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("Timeout: run did not finish within %0d ns", LIMIT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

/* verif/mpu6050_model.sv */
// behavioral MPU6050 I2C slave for the testbench, with burst registers and address NACK injection
`timescale 1ns/1ns
`include "imu_defines.svh"

module mpu6050_model (
    input  logic         scl_i,
    input  logic         sda_i,
    input  logic [111:0] burst_i,      // byte 0 in the top bits
    input  logic         nack_addr_i,
    output logic         sda_oe_o,
    output logic [7:0]   wr_cnt_o,
    output logic [7:0]   wr_reg_o,
    output logic [7:0]   wr_data_o,
    output logic         rd_before_wr_o
);

    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       reading;
    logic       ack_me;
    logic       rd_pending;
    logic [3:0] bitpos;       // 8 is the ack slot
    logic [1:0] byte_num;
    logic [7:0] rx_sr;
    logic [7:0] tx_byte;
    logic [7:0] reg_ptr;

    function automatic logic [7:0] reg_value(input logic [7:0] addr);
        logic [111:0] sh;
        sh = burst_i << (8 * (addr - `IMU_REG_ACCEL));
        if (addr == `IMU_REG_WHOAMI)
            return 8'h68;
        if (addr >= `IMU_REG_ACCEL && addr < `IMU_REG_ACCEL + 8'd14)
            return sh[111:104];
        return 8'h00;
    endfunction

    initial begin
        scl_q = 1'b1;
        sda_q = 1'b1;
        active = 1'b0;
        reading = 1'b0;
        ack_me = 1'b0;
        rd_pending = 1'b0;
        bitpos = '0;
        byte_num = '0;
        rx_sr = '0;
        tx_byte = '0;
        reg_ptr = '0;
        sda_oe_o = 1'b0;
        wr_cnt_o = '0;
        wr_reg_o = '0;
        wr_data_o = '0;
        rd_before_wr_o = 1'b0;
    end

    always @(scl_i or sda_i) begin
        if (scl_i && scl_q && sda_q && !sda_i) begin
            active = 1'b1;  // start or repeated start
            reading = 1'b0;
            ack_me = 1'b0;
            rd_pending = 1'b0;
            bitpos = '0;
            byte_num = '0;
        end else if (scl_i && scl_q && !sda_q && sda_i) begin
            active = 1'b0;  // stop
            sda_oe_o <= 1'b0;
        end else if (scl_i && !scl_q && active) begin
            if (bitpos < 4'd8) begin
                rx_sr = {rx_sr[6:0], sda_i};
                bitpos = bitpos + 4'd1;
                if (bitpos == 4'd8 && !reading) begin
                    case (byte_num)
                        2'd0: begin
                            ack_me = (rx_sr[7:1] == `IMU_DEV_ADDR) && !nack_addr_i;
                            rd_pending = rx_sr[0];
                        end
                        2'd1: begin
                            ack_me = 1'b1;
                            reg_ptr = rx_sr;
                        end
                        default: begin
                            ack_me = 1'b1;
                            wr_cnt_o = wr_cnt_o + 8'd1;
                            wr_reg_o = reg_ptr;
                            wr_data_o = rx_sr;
                        end
                    endcase
                    if (byte_num != 2'd2)
                        byte_num = byte_num + 2'd1;
                end
            end else begin
                bitpos = '0;
                if (reading) begin
                    if (sda_i) begin
                        active = 1'b0;  // master nack ends the read
                    end else begin
                        reg_ptr = reg_ptr + 8'd1;
                        tx_byte = reg_value(reg_ptr);
                    end
                end else if (!ack_me) begin
                    active = 1'b0;
                end else if (rd_pending) begin
                    reading = 1'b1;
                    tx_byte = reg_value(reg_ptr);
                    if (wr_cnt_o == 8'd0)
                        rd_before_wr_o = 1'b1;
                end
                ack_me = 1'b0;
            end
        end else if (!scl_i && scl_q) begin
            if (active && bitpos == 4'd8 && ack_me)
                sda_oe_o <= 1'b1;
            else if (active && reading && bitpos < 4'd8)
                sda_oe_o <= ~tx_byte[3'd7 - bitpos[2:0]];
            else
                sda_oe_o <= 1'b0;
        end
        scl_q = scl_i;
        sda_q = sda_i;
    end

endmodule
